/* ctrlUnit.f */
+incdir+verilog
verilog/ctrlPkg.sv
verilog/opDecoder.sv
verilog/stepSequencer.sv
verilog/controlOutputs.sv
verilog/ctrlUnit.sv
testbench/ctrlUnit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ctrlUnit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    -f ctrlUnit.f \
    --top-module ctrlUnit_tb \
    -Mdir obj_dir

./obj_dir/VctrlUnit_tb | tee "$LOG"

if grep -q "All checks passed" "$LOG"; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

/* testbench/ctrlUnit_tb.sv */
`timescale 1ns/10ps

module ctrlUnit_tb import ctrlPkg::*; ();

    localparam int OP_W = $bits(opcode_e);
    localparam int RESET_CYCLES = 16;
    localparam int MAX_GAP = 3;
    localparam int TIMEOUT_MARGIN = 8;
    localparam int HANG_MARGIN = 4;

    logic        clk;
    logic        rst;
    opcode_e     opcode;
    logic        opValid;
    logic        interrupt;
    logic        busy;
    aluOp_e      aluOp;
    logic        aluSource;
    branchCond_e branch;
    logic        writeReg;
    logic        memRead;
    logic        memWrite;
    logic        memRegPC;

    logic [OP_W-1:0] traceOp[$];
    int              traceDelay[$];
    aluOp_e          traceAluOp[$];
    logic            traceAluSrc[$];
    branchCond_e     traceBranch[$];
    int              traceLen[$];

    int   valueErrors = 0;
    int   countErrors = 0;
    int   otherErrors = 0;
    int   cycleCount = 0;
    int   cycleLimit = 0;
    logic hung = 1'b0;

    ctrlUnit uut (
        .clk       (clk),
        .rst       (rst),
        .opcode    (opcode),
        .opValid   (opValid),
        .interrupt (interrupt),
        .busy      (busy),
        .aluOp     (aluOp),
        .aluSource (aluSource),
        .branch    (branch),
        .writeReg  (writeReg),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .memRegPC  (memRegPC)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Run stopped after %0d cycles before the trace was finished", cycleCount);
            $display("Errors: value=%0d length=%0d other=%0d",
                     valueErrors, countErrors, otherErrors + 1);
            $display("Checks failed");
            $finish;
        end
    end

    // ##############################
    // Compare tasks
    // ##############################
    task automatic checkAluOp(input string name, input aluOp_e actual, input aluOp_e expected);
        if (actual !== expected) begin
            valueErrors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkBranch(input string name, input branchCond_e actual,
                               input branchCond_e expected);
        if (actual !== expected) begin
            valueErrors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            valueErrors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected) begin
            countErrors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic checkIdle();
        checkBit("busy", busy, 1'b0);
        checkAluOp("aluOp", aluOp, ALU_PASS);
        checkBit("aluSource", aluSource, 1'b0);
        checkBranch("branch", branch, COND_NONE);
        checkBit("writeReg", writeReg, 1'b0);
        checkBit("memRead", memRead, 1'b0);
        checkBit("memWrite", memWrite, 1'b0);
        checkBit("memRegPC", memRegPC, 1'b0);
    endtask

    // Expected strobes for busy cycle k of one instruction
    task automatic checkBusyCycle(input int k, input logic [OP_W-1:0] op, input aluOp_e expAlu,
                                  input logic expSrc, input branchCond_e expBr);
        logic isLoad;
        logic isStore;
        logic aluWrite;
        isLoad = (op == OP_LD);
        isStore = (op == OP_ST);
        aluWrite = (expAlu != ALU_PASS); // REG and IMM write back
        checkAluOp("aluOp", aluOp, expAlu);
        checkBit("aluSource", aluSource, expSrc);
        checkBranch("branch", branch, expBr);
        checkBit("writeReg", writeReg, (aluWrite && k == 1) || (isLoad && k == 2));
        checkBit("memRead", memRead, isLoad && (k == 1 || k == 2));
        checkBit("memWrite", memWrite, isStore && k == 1);
        checkBit("memRegPC", memRegPC, isLoad && k == 2);
    endtask

    // ##############################
    // Trace reader
    // ##############################
    task automatic readTrace();
        int          fd;
        int          code;
        string       line;
        logic [31:0] fOp;
        logic [31:0] fDelay;
        logic [31:0] fAlu;
        logic [31:0] fSrc;
        logic [31:0] fBr;
        logic [31:0] fLen;
        fd = $fopen("testbench/ctrlUnit_trace.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Could not open the trace file testbench/ctrlUnit_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h %h", fOp, fDelay, fAlu, fSrc, fBr, fLen);
                    if (code == 6) begin
                        traceOp.push_back(fOp[OP_W-1:0]);
                        traceDelay.push_back(int'(fDelay));
                        traceAluOp.push_back(aluOp_e'(fAlu[3:0]));
                        traceAluSrc.push_back(fSrc[0]);
                        traceBranch.push_back(branchCond_e'(fBr[2:0]));
                        traceLen.push_back(int'(fLen));
                    end
                end
            end
            $fclose(fd);
            if (traceOp.size() == 0) begin
                otherErrors++;
                $display("The trace file holds no instructions");
            end
        end
    endtask

    task automatic computeLimit();
        int maxSteps;
        int maxDelay;
        maxSteps = 0;
        maxDelay = 0;
        foreach (traceOp[i]) begin
            if (traceOp[i] == OP_HALT) begin
                if (traceDelay[i] > maxDelay) begin
                    maxDelay = traceDelay[i];
                end
            end else if (traceLen[i] > maxSteps) begin
                maxSteps = traceLen[i];
            end
        end
        cycleLimit = traceOp.size() * (maxSteps + maxDelay + MAX_GAP + TIMEOUT_MARGIN)
                     + RESET_CYCLES + TIMEOUT_MARGIN;
    endtask

    // ##############################
    // One instruction
    // ##############################
    task automatic runInstr(input int idx);
        logic [OP_W-1:0] op;
        int              delay;
        int              expLen;
        int              gap;
        int              k;
        logic            isHalt;
        logic            done;
        op = traceOp[idx];
        delay = traceDelay[idx];
        expLen = traceLen[idx];
        isHalt = (op == OP_HALT);
        gap = int'($urandom % (MAX_GAP + 1));
        repeat (gap) begin
            @(posedge clk);
            interrupt <= 1'b0;
            @(negedge clk);
            checkIdle();
        end
        @(posedge clk);
        opcode <= opcode_e'(op);
        opValid <= 1'b1;
        interrupt <= 1'b0;
        @(negedge clk);
        checkIdle(); // Accept happens on the next edge
        k = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (k < expLen && ($urandom % 3) == 0) begin
                opValid <= 1'b1; // Must be ignored while busy
                opcode <= (op == OP_LD) ? OP_ALU : OP_LD;
            end else begin
                opValid <= 1'b0;
                opcode <= OP_NOP;
            end
            if (isHalt) begin
                interrupt <= (k == delay);
            end else begin
                interrupt <= ($urandom % 2) == 1;
            end
            @(negedge clk);
            if (!busy) begin
                done = 1'b1;
                checkIdle();
            end else begin
                checkBusyCycle(k, op, traceAluOp[idx], traceAluSrc[idx], traceBranch[idx]);
                k++;
                if (k > expLen + HANG_MARGIN) begin
                    otherErrors++;
                    hung = 1'b1;
                    $display("busy stayed high for more than %0d cycles after opcode 0x%h",
                             k, op);
                    done = 1'b1;
                end
            end
        end
        checkCount("busyLength", k, expLen);
    endtask

    initial begin
        int idx;
        rst <= 1'b1;
        opcode <= OP_NOP;
        opValid <= 1'b0;
        interrupt <= 1'b0;
        idx = int'($urandom(51));
        readTrace();
        computeLimit();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            checkIdle();
        end
        for (idx = 0; idx < traceOp.size() && !hung; idx++) begin
            runInstr(idx);
        end
        @(negedge clk);
        checkIdle();
        $display("Errors: value=%0d length=%0d other=%0d", valueErrors, countErrors, otherErrors);
        if (valueErrors + countErrors + otherErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* testbench/ctrlUnit_trace.txt */
# opcode haltDelay aluOp aluSource branch busyLength (all hex)
# haltDelay is the number of HALT wait cycles before interrupt, 0 for other opcodes
00 0 1 1 0 3
01 0 2 0 0 3
05 0 3 0 0 3
07 0 7 0 0 3
08 0 8 0 0 3
09 0 9 0 0 3
0b 0 a 0 0 3
0c 0 4 0 0 3
0d 0 5 0 0 3
0f 0 6 0 0 3
10 0 b 0 0 3
11 0 c 0 0 3
12 0 d 0 0 3
25 0 2 0 0 3
15 0 0 0 0 4
19 0 0 0 0 3
02 0 0 0 1 2
06 0 0 0 3 2
0a 0 0 0 5 2
0e 0 0 0 7 2
22 3 0 0 0 4
26 0 0 0 0 1
3f 0 0 0 0 1
22 1 0 0 0 2
15 0 0 0 0 4
04 0 0 0 0 1
22 6 0 0 0 7
00 0 1 1 0 3

/* verilog/controlOutputs.sv */
`timescale 1ns/10ps

`include "ctrl_defs.svh"

module controlOutputs import ctrlPkg::*; (
    input  instrClass_e        instrClass,
    input  seqPhase_e          phase,
    input  logic [`STEP_W-1:0] step,
    input  aluOp_e             aluOpIn,
    input  logic               aluSourceIn,
    input  branchCond_e        branchIn,
    output aluOp_e             aluOp,
    output logic               aluSource,
    output branchCond_e        branch,
    output logic               writeReg,
    output logic               memRead,
    output logic               memWrite,
    output logic               memRegPC
);

    logic inExec;
    logic stepOne;
    logic stepTwo;

    assign inExec = (phase == PH_EXEC);
    assign stepOne = (step == `STEP_W'(1));
    assign stepTwo = (step == `STEP_W'(2));

    // ##############################
    // Strobe table
    // ##############################
    always_comb begin
        aluOp = ALU_PASS;
        aluSource = 1'b0;
        branch = COND_NONE;
        writeReg = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        memRegPC = 1'b0;

        if (phase != PH_IDLE) begin // Decoded fields only while busy
            aluOp = aluOpIn;
            aluSource = aluSourceIn;
            branch = branchIn;
        end

        if (inExec) begin
            case (instrClass)
                CLS_REG, CLS_IMM: begin
                    writeReg = stepOne; // Write back ALU result
                end
                CLS_LOAD: begin
                    memRead = stepOne || stepTwo;
                    writeReg = stepTwo;
                    memRegPC = stepTwo; // Select memory data for write back
                end
                CLS_STORE: begin
                    memWrite = stepOne;
                end
                default: begin
                    writeReg = 1'b0;
                end
            endcase
        end
    end

endmodule

/* verilog/ctrlPkg.sv */
`include "ctrl_defs.svh"

package ctrlPkg;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_ALU  = 6'b000000,
        OP_ADDI = 6'b000001,
        OP_SUBI = 6'b000101,
        OP_ANDI = 6'b000111,
        OP_ORI  = 6'b001000,
        OP_XORI = 6'b001001,
        OP_NORI = 6'b001011,
        OP_SLAI = 6'b001100,
        OP_SRAI = 6'b001101,
        OP_SRLI = 6'b001111,
        OP_SLTI = 6'b010000,
        OP_SGTI = 6'b010001,
        OP_LUI  = 6'b010010,
        OP_LD   = 6'b010101,
        OP_ST   = 6'b011001,
        OP_MOVE = 6'b100101, // Same as ADDI
        OP_BR   = 6'b000010,
        OP_BMI  = 6'b000110,
        OP_BPL  = 6'b001010,
        OP_BZ   = 6'b001110,
        OP_HALT = 6'b100010,
        OP_NOP  = 6'b100110
    } opcode_e;

    typedef enum logic [`ALUOP_W-1:0] {
        ALU_PASS = 4'd0,
        ALU_REG  = 4'd1, // Function field picks the op
        ALU_ADD  = 4'd2,
        ALU_SUB  = 4'd3,
        ALU_SLA  = 4'd4,
        ALU_SRA  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_AND  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_XOR  = 4'd9,
        ALU_NOR  = 4'd10,
        ALU_SLT  = 4'd11,
        ALU_SGT  = 4'd12,
        ALU_LUI  = 4'd13
    } aluOp_e;

    typedef enum logic [`BRANCH_W-1:0] {
        COND_NONE   = 3'b000,
        COND_ALWAYS = 3'b001,
        COND_MINUS  = 3'b011,
        COND_PLUS   = 3'b101,
        COND_ZERO   = 3'b111
    } branchCond_e;

    typedef enum logic [2:0] {
        CLS_REG, CLS_IMM, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_HALT, CLS_NOP
    } instrClass_e;

    typedef enum logic [1:0] {
        PH_IDLE, PH_EXEC, PH_WAITINT
    } seqPhase_e;

endpackage

/* verilog/ctrlUnit.sv */
`timescale 1ns/10ps

`include "ctrl_defs.svh"

module ctrlUnit import ctrlPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  opcode_e     opcode,
    input  logic        opValid,
    input  logic        interrupt,
    output logic        busy,
    output aluOp_e      aluOp,
    output logic        aluSource,
    output branchCond_e branch,
    output logic        writeReg,
    output logic        memRead,
    output logic        memWrite,
    output logic        memRegPC
);

    logic               accept;
    instrClass_e        instrClass;
    aluOp_e             decAluOp;
    logic               decAluSource;
    branchCond_e        decBranch;
    seqPhase_e          phase;
    logic [`STEP_W-1:0] step;

    opDecoder decoder (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .accept     (accept),
        .instrClass (instrClass),
        .aluOp      (decAluOp),
        .aluSource  (decAluSource),
        .branch     (decBranch)
    );

    stepSequencer sequencer (
        .clk        (clk),
        .rst        (rst),
        .opValid    (opValid),
        .instrClass (instrClass),
        .interrupt  (interrupt),
        .accept     (accept),
        .busy       (busy),
        .phase      (phase),
        .step       (step)
    );

    controlOutputs outputs (
        .instrClass  (instrClass),
        .phase       (phase),
        .step        (step),
        .aluOpIn     (decAluOp),
        .aluSourceIn (decAluSource),
        .branchIn    (decBranch),
        .aluOp       (aluOp),
        .aluSource   (aluSource),
        .branch      (branch),
        .writeReg    (writeReg),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memRegPC    (memRegPC)
    );

endmodule

/* verilog/ctrl_defs.svh */
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// ##############################
// Field widths
// ##############################
`define OPCODE_W 6
`define ALUOP_W 4
`define BRANCH_W 3
`define STEP_W 3

// ##############################
// Micro-steps per instruction class
// ##############################
`define REG_STEPS 3
`define IMM_STEPS 3
`define LOAD_STEPS 4 // Address, read, write back
`define STORE_STEPS 3
`define BRANCH_STEPS 2
`define NOP_STEPS 1

`endif

/* verilog/opDecoder.sv */
`timescale 1ns/10ps

module opDecoder import ctrlPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  opcode_e     opcode,
    input  logic        accept,
    output instrClass_e instrClass,
    output aluOp_e      aluOp,
    output logic        aluSource,
    output branchCond_e branch
);

    instrClass_e decClass;
    aluOp_e      decAluOp;
    logic        decAluSource;
    branchCond_e decBranch;

    // ##############################
    // Opcode decode
    // ##############################
    always_comb begin
        decClass = CLS_NOP; // Unlisted opcodes run as NOP
        decAluOp = ALU_PASS;
        decAluSource = 1'b0;
        decBranch = COND_NONE;
        case (opcode)
            OP_ALU: begin
                decClass = CLS_REG;
                decAluOp = ALU_REG;
                decAluSource = 1'b1; // Second operand from register file
            end
            OP_ADDI, OP_MOVE: begin
                decClass = CLS_IMM;
                decAluOp = ALU_ADD;
            end
            OP_SUBI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_SUB;
            end
            OP_SLAI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_SLA;
            end
            OP_SRAI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_SRA;
            end
            OP_SRLI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_SRL;
            end
            OP_ANDI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_AND;
            end
            OP_ORI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_OR;
            end
            OP_XORI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_XOR;
            end
            OP_NORI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_NOR;
            end
            OP_SLTI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_SLT;
            end
            OP_SGTI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_SGT;
            end
            OP_LUI: begin
                decClass = CLS_IMM;
                decAluOp = ALU_LUI;
            end
            OP_LD: decClass = CLS_LOAD;
            OP_ST: decClass = CLS_STORE;
            OP_BR: begin
                decClass = CLS_BRANCH;
                decBranch = COND_ALWAYS;
            end
            OP_BMI: begin
                decClass = CLS_BRANCH;
                decBranch = COND_MINUS;
            end
            OP_BPL: begin
                decClass = CLS_BRANCH;
                decBranch = COND_PLUS;
            end
            OP_BZ: begin
                decClass = CLS_BRANCH;
                decBranch = COND_ZERO;
            end
            OP_HALT: decClass = CLS_HALT;
            default: decClass = CLS_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instrClass <= CLS_NOP;
            aluOp <= ALU_PASS;
            aluSource <= 1'b0;
            branch <= COND_NONE;
        end else if (accept) begin // Held until next accept
            instrClass <= decClass;
            aluOp <= decAluOp;
            aluSource <= decAluSource;
            branch <= decBranch;
        end
    end

endmodule

/* verilog/stepSequencer.sv */
`timescale 1ns/10ps

`include "ctrl_defs.svh"

module stepSequencer import ctrlPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               opValid,
    input  instrClass_e        instrClass,
    input  logic               interrupt,
    output logic               accept,
    output logic               busy,
    output seqPhase_e          phase,
    output logic [`STEP_W-1:0] step
);

    logic [`STEP_W-1:0] lastStep;

    assign accept = (phase == PH_IDLE) && opValid; // Ignored while busy
    assign busy = (phase != PH_IDLE);

    // ##############################
    // Last micro-step per class
    // ##############################
    always_comb begin
        case (instrClass)
            CLS_REG:    lastStep = `STEP_W'(`REG_STEPS - 1);
            CLS_IMM:    lastStep = `STEP_W'(`IMM_STEPS - 1);
            CLS_LOAD:   lastStep = `STEP_W'(`LOAD_STEPS - 1);
            CLS_STORE:  lastStep = `STEP_W'(`STORE_STEPS - 1);
            CLS_BRANCH: lastStep = `STEP_W'(`BRANCH_STEPS - 1);
            CLS_NOP:    lastStep = `STEP_W'(`NOP_STEPS - 1);
            default:    lastStep = '0; // HALT has one step, then waits
        endcase
    end

    // ##############################
    // Phase FSM and step counter
    // ##############################
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_IDLE;
            step <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (accept) begin
                        phase <= PH_EXEC;
                        step <= '0;
                    end
                end
                PH_EXEC: begin
                    if (step == lastStep) begin
                        step <= '0;
                        if (instrClass == CLS_HALT) begin
                            phase <= PH_WAITINT;
                        end else begin
                            phase <= PH_IDLE;
                        end
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                PH_WAITINT: begin
                    if (interrupt) begin // Release from HALT
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule
